// ==== fetch_pkg.sv ====
package fetch_pkg;

    // --------------------------------------
    // Sizes
    // --------------------------------------
    localparam int XLEN        = 32;           // PC and instruction width.
    localparam int FETCH_SLOTS = 4;            // Instructions per group.
    localparam int SLOT_BITS   = 2;            // Slot index width.
    localparam int IBUF_DEPTH  = 4;            // Groups held for decode.
    localparam int RAS_DEPTH   = 4;            // Return stack entries.

    localparam logic [XLEN-1:0] BOOT_PC = 32'h0000_0100;

    // RV32I major opcodes seen by the quick decoder.
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // --------------------------------------
    // Plain vector types
    // --------------------------------------
    typedef logic [XLEN-1:0]        pc_t;
    typedef logic [XLEN-1:0]        inst_t;
    typedef logic [SLOT_BITS-1:0]   slot_idx_t;
    typedef logic [FETCH_SLOTS-1:0] slot_mask_t;

    typedef enum logic [2:0] {
        QD_NORMAL,
        QD_BRANCH,
        QD_JAL,
        QD_CALL,
        QD_JALR,
        QD_RET
    } qd_type_e;

    // --------------------------------------
    // Bundles
    // --------------------------------------
    typedef struct packed {
        pc_t                     base_pc;      // Group address, 16-byte aligned.
        inst_t [FETCH_SLOTS-1:0] insts;
        slot_mask_t              avail;        // Slots inside the window.
        pc_t                     pred_npc;
    } fetch_grp_t;

    typedef struct packed {
        logic en;
        pc_t  pc;
    } redirect_t;

    typedef struct packed {
        logic push;
        logic pop;
        pc_t  push_addr;                       // Return address of a call.
    } ras_op_t;

endpackage

// ==== fetch_pc_gen.sv ====
`timescale 1ns/1ns

module fetch_pc_gen import fetch_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      fetch_en_i,
    input  redirect_t redirect_i,
    input  logic      ibuf_afull_i,
    input  pc_t       pred_npc_i,
    input  logic      imem_ok_i,
    output logic      imem_req_o,
    output pc_t       imem_addr_o,
    output pc_t       cur_pc_o,
    output logic      resp_ok_o
);

    pc_t  cur_pc;
    pc_t  next_pc;
    logic req_pending;

    // A response only counts when it answers our request.
    assign resp_ok_o = req_pending & imem_ok_i & ~redirect_i.en;

    always_comb begin
        if (redirect_i.en) begin
            next_pc = redirect_i.pc;           // Restart wins.
        end else if (resp_ok_o) begin
            next_pc = pred_npc_i;
        end else begin
            next_pc = cur_pc;                  // Retry or hold.
        end
    end

    // One request may be in flight, the buffer leaves room for it.
    assign imem_req_o  = fetch_en_i & ~ibuf_afull_i;
    assign imem_addr_o = {next_pc[XLEN-1:SLOT_BITS+2], {(SLOT_BITS+2){1'b0}}};
    assign cur_pc_o    = cur_pc;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cur_pc      <= BOOT_PC;
            req_pending <= 1'b0;
        end else begin
            cur_pc      <= next_pc;
            req_pending <= imem_req_o;
        end
    end

    // --------------------------------------
    // Checks
    // --------------------------------------
    a_req_aligned : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        imem_req_o |-> (imem_addr_o[SLOT_BITS+1:0] == '0)
    );

endmodule

// ==== predecode.sv ====
`timescale 1ns/1ns

module predecode import fetch_pkg::*; (
    input  inst_t    inst_i,
    input  pc_t      pc_i,
    output qd_type_e qd_type_o,
    output pc_t      target_o
);

    logic [6:0] opcode;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic       rd_link;
    logic       rs1_link;
    pc_t        j_imm;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];

    // x1 and x5 are the link registers.
    assign rd_link  = (rd == 5'd1) || (rd == 5'd5);
    assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

    assign j_imm = {{(XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    always_comb begin
        case (opcode)
            OPC_BRANCH: begin
                qd_type_o = QD_BRANCH;
            end
            OPC_JAL: begin
                qd_type_o = rd_link ? QD_CALL : QD_JAL;
            end
            OPC_JALR: begin
                qd_type_o = (rd == 5'd0 && rs1_link) ? QD_RET : QD_JALR;
            end
            default: begin
                qd_type_o = QD_NORMAL;
            end
        endcase
    end

    assign target_o = pc_i + j_imm;            // Only meaningful for JAL.

endmodule

// ==== group_select.sv ====
`timescale 1ns/1ns

module group_select import fetch_pkg::*; (
    input  pc_t                        cur_pc_i,
    input  inst_t    [FETCH_SLOTS-1:0] insts_i,
    input  logic                       resp_ok_i,
    input  qd_type_e [FETCH_SLOTS-1:0] qd_types_i,
    input  pc_t      [FETCH_SLOTS-1:0] targets_i,
    input  pc_t                        ras_top_i,
    input  logic                       ras_empty_i,
    output fetch_grp_t                 grp_o,
    output ras_op_t                    ras_op_o
);

    pc_t [FETCH_SLOTS-1:0] slot_pc;
    pc_t                   base_pc;
    slot_idx_t             start_slot;
    slot_idx_t             last_slot;
    logic                  found;
    qd_type_e              last_type;
    pc_t                   seq_npc;
    slot_mask_t            avail;

    assign base_pc    = {cur_pc_i[XLEN-1:SLOT_BITS+2], {(SLOT_BITS+2){1'b0}}};
    assign start_slot = cur_pc_i[SLOT_BITS+1:2];

    for (genvar g = 0; g < FETCH_SLOTS; g++) begin : g_slot
        assign slot_pc[g] = {cur_pc_i[XLEN-1:SLOT_BITS+2], slot_idx_t'(g), 2'b00};
        assign avail[g]   = (g >= start_slot) && (g <= last_slot);
    end

    // --------------------------------------
    // Window end
    // --------------------------------------
    always_comb begin
        last_slot = slot_idx_t'(FETCH_SLOTS-1);
        found     = 1'b0;
        for (int i = 0; i < FETCH_SLOTS; i++) begin
            if (!found && i >= start_slot && qd_types_i[i] != QD_NORMAL) begin
                last_slot = slot_idx_t'(i);   // First control flow wins.
                found     = 1'b1;
            end
        end
    end

    assign last_type = qd_types_i[last_slot];
    assign seq_npc   = slot_pc[last_slot] + pc_t'(4);

    always_comb begin
        grp_o.base_pc = base_pc;
        grp_o.insts   = insts_i;
        grp_o.avail   = avail;
        case (last_type)
            QD_JAL, QD_CALL: grp_o.pred_npc = targets_i[last_slot];
            QD_RET:          grp_o.pred_npc = ras_empty_i ? seq_npc : ras_top_i;
            default:         grp_o.pred_npc = seq_npc;   // Branches not taken.
        endcase
    end

    // Stack only moves for groups that are kept.
    assign ras_op_o.push      = resp_ok_i & (last_type == QD_CALL);
    assign ras_op_o.pop       = resp_ok_i & (last_type == QD_RET);
    assign ras_op_o.push_addr = seq_npc;

endmodule

// ==== ras.sv ====
`timescale 1ns/1ns

module ras import fetch_pkg::*; (
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  logic    clear_i,
    input  ras_op_t op_i,
    output pc_t     top_o,
    output logic    empty_o
);

    pc_t                          stack [RAS_DEPTH];
    logic [$clog2(RAS_DEPTH)-1:0] wr_ptr;      // Next free entry.
    logic [$clog2(RAS_DEPTH):0]   count;

    assign top_o   = stack[wr_ptr - 1'b1];
    assign empty_o = (count == '0);

    always_ff @(posedge clk_i) begin
        if (op_i.push) begin
            stack[wr_ptr] <= op_i.push_addr;   // Wraps over the oldest.
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            count  <= '0;
        end else if (clear_i) begin
            wr_ptr <= '0;
            count  <= '0;
        end else if (op_i.push) begin
            wr_ptr <= wr_ptr + 1'b1;
            if (count != RAS_DEPTH) begin
                count <= count + 1'b1;
            end
        end else if (op_i.pop && !empty_o) begin
            wr_ptr <= wr_ptr - 1'b1;
            count  <= count - 1'b1;
        end
    end

    a_no_push_pop : assert property (
        @(posedge clk_i) disable iff (!arst_n_i) !(op_i.push && op_i.pop)
    );

endmodule

// ==== fetch_ibuf.sv ====
`timescale 1ns/1ns

module fetch_ibuf import fetch_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       flush_i,
    input  logic       push_i,
    input  fetch_grp_t grp_i,
    output logic       afull_o,
    output logic       grp_vld_o,
    output fetch_grp_t grp_o,
    input  logic       grp_rdy_i
);

    fetch_grp_t                    mem [IBUF_DEPTH];
    logic [$clog2(IBUF_DEPTH)-1:0] wr_ptr;
    logic [$clog2(IBUF_DEPTH)-1:0] rd_ptr;
    logic [$clog2(IBUF_DEPTH):0]   count;
    logic                          pop;

    assign grp_vld_o = (count != '0) & ~flush_i;
    assign pop       = grp_vld_o & grp_rdy_i;
    assign grp_o     = mem[rd_ptr];

    // Keep one slot for the request already in flight.
    assign afull_o = (count >= IBUF_DEPTH - 1);

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr] <= grp_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_i, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // --------------------------------------
    // Checks
    // --------------------------------------
    a_no_overflow : assert property (
        @(posedge clk_i) disable iff (!arst_n_i) push_i |-> count < IBUF_DEPTH
    );

    a_hold_stable : assert property (
        @(posedge clk_i) disable iff (!arst_n_i || flush_i)
        grp_vld_o && !grp_rdy_i |=> $stable(grp_o)
    );

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top import fetch_pkg::*; (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    fetch_en_i,
    input  redirect_t               redirect_i,
    output logic                    imem_req_o,
    output pc_t                     imem_addr_o,
    input  logic                    imem_ok_i,
    input  inst_t [FETCH_SLOTS-1:0] imem_insts_i,
    output logic                    grp_vld_o,
    output fetch_grp_t              grp_o,
    input  logic                    grp_rdy_i
);

    logic                       fetch_en_q;
    redirect_t                  redirect_q;
    pc_t                        cur_pc;
    logic                       resp_ok;
    qd_type_e [FETCH_SLOTS-1:0] qd_types;
    pc_t      [FETCH_SLOTS-1:0] targets;
    fetch_grp_t                 resp_grp;
    ras_op_t                    ras_op;
    pc_t                        ras_top;
    logic                       ras_empty;
    logic                       ibuf_afull;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fetch_en_q <= 1'b0;
            redirect_q <= '0;
        end else begin
            fetch_en_q <= fetch_en_i;
            redirect_q <= redirect_i;
        end
    end

    fetch_pc_gen u_pc_gen (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .fetch_en_i   (fetch_en_q),
        .redirect_i   (redirect_q),
        .ibuf_afull_i (ibuf_afull),
        .pred_npc_i   (resp_grp.pred_npc),
        .imem_ok_i    (imem_ok_i),
        .imem_req_o   (imem_req_o),
        .imem_addr_o  (imem_addr_o),
        .cur_pc_o     (cur_pc),
        .resp_ok_o    (resp_ok)
    );

    for (genvar g = 0; g < FETCH_SLOTS; g++) begin : g_qd
        predecode u_predecode (
            .inst_i    (imem_insts_i[g]),
            .pc_i      ({cur_pc[XLEN-1:SLOT_BITS+2], slot_idx_t'(g), 2'b00}),
            .qd_type_o (qd_types[g]),
            .target_o  (targets[g])
        );
    end

    group_select u_group_select (
        .cur_pc_i    (cur_pc),
        .insts_i     (imem_insts_i),
        .resp_ok_i   (resp_ok),
        .qd_types_i  (qd_types),
        .targets_i   (targets),
        .ras_top_i   (ras_top),
        .ras_empty_i (ras_empty),
        .grp_o       (resp_grp),
        .ras_op_o    (ras_op)
    );

    ras u_ras (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .clear_i  (redirect_q.en),             // New stream, no return history.
        .op_i     (ras_op),
        .top_o    (ras_top),
        .empty_o  (ras_empty)
    );

    fetch_ibuf u_ibuf (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .flush_i   (redirect_q.en),
        .push_i    (resp_ok),
        .grp_i     (resp_grp),
        .afull_o   (ibuf_afull),
        .grp_vld_o (grp_vld_o),
        .grp_o     (grp_o),
        .grp_rdy_i (grp_rdy_i)
    );

endmodule

// ==== tb_fetch_top.sv ====
`timescale 1ns/1ns

module tb_fetch_top import fetch_pkg::*; ();

    localparam int MEM_WORDS        = 256;
    localparam int MAX_GROUPS       = 400;
    localparam int CYCLES_PER_GROUP = 40;
    localparam int CLK_PERIOD       = 100;

    logic                    clk_i;
    logic                    arst_n_i;
    logic                    fetch_en_i;
    redirect_t               redirect_i;
    logic                    imem_req_o;
    pc_t                     imem_addr_o;
    logic                    imem_ok_i;
    inst_t [FETCH_SLOTS-1:0] imem_insts_i;
    logic                    grp_vld_o;
    fetch_grp_t              grp_o;
    logic                    grp_rdy_i;

    inst_t  prog [MEM_WORDS];
    integer seed;
    int     errors;
    int     groups;
    logic   req_q;                             // Request of the previous cycle.
    pc_t    addr_q;
    logic   redirect_prev;

    pc_t    model_pc;
    pc_t    model_ras [RAS_DEPTH];
    int     model_ras_ptr;
    int     model_ras_cnt;

    fetch_top uut (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .fetch_en_i   (fetch_en_i),
        .redirect_i   (redirect_i),
        .imem_req_o   (imem_req_o),
        .imem_addr_o  (imem_addr_o),
        .imem_ok_i    (imem_ok_i),
        .imem_insts_i (imem_insts_i),
        .grp_vld_o    (grp_vld_o),
        .grp_o        (grp_o),
        .grp_rdy_i    (grp_rdy_i)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // --------------------------------------
    // Program memory and decode rules
    // --------------------------------------
    function automatic inst_t mem_word(input pc_t addr);
        return prog[addr[9:2]];                // Memory repeats every 1 KiB.
    endfunction

    function automatic qd_type_e classify(input inst_t inst);
        logic rd_link;
        logic rs1_link;
        rd_link  = (inst[11:7] == 5'd1) || (inst[11:7] == 5'd5);
        rs1_link = (inst[19:15] == 5'd1) || (inst[19:15] == 5'd5);
        case (inst[6:0])
            7'b1100011: return QD_BRANCH;
            7'b1101111: return rd_link ? QD_CALL : QD_JAL;
            7'b1100111: return (inst[11:7] == 5'd0 && rs1_link) ? QD_RET : QD_JALR;
            default:    return QD_NORMAL;
        endcase
    endfunction

    function automatic pc_t jump_offset(input inst_t inst);
        return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

    task automatic fill_program();
        logic [31:0] rnd;
        int          kind;
        int          off;
        for (int i = 0; i < MEM_WORDS; i++) begin
            rnd  = $random(seed);
            kind = {$random(seed)} % 16;
            off  = ({$random(seed)} % MEM_WORDS - i) * 4;   // Jump lands inside memory.
            if (kind < 8) begin
                prog[i] = {rnd[31:7], 7'b0010011};
            end else if (kind < 10) begin
                prog[i] = {rnd[31:7], 7'b1100011};
            end else if (kind < 13) begin
                // JAL links x0, CALL links x1 or x5
                prog[i] = {off[20], off[10:1], off[11], off[19:12],
                           (kind == 10) ? 5'd0 : (rnd[0] ? 5'd1 : 5'd5), 7'b1101111};
            end else if (kind < 15) begin
                prog[i] = {12'h000, rnd[0] ? 5'd1 : 5'd5, 3'b000, 5'd0, 7'b1100111};
            end else begin
                prog[i] = {rnd[31:20], 5'd6, 3'b000, 5'd2, 7'b1100111};
            end
        end
    endtask

    // --------------------------------------
    // Reference model
    // --------------------------------------
    task automatic restart_model(input pc_t pc);
        model_pc      = pc;
        model_ras_ptr = 0;
        model_ras_cnt = 0;
    endtask

    task automatic predict_group(output fetch_grp_t exp);
        int  start;
        int  last;
        pc_t slot_pc;
        pc_t seq_npc;
        exp.base_pc = {model_pc[XLEN-1:4], 4'b0000};
        start       = model_pc[3:2];
        for (int i = 0; i < FETCH_SLOTS; i++) begin
            exp.insts[i] = mem_word(exp.base_pc + pc_t'(4 * i));
        end
        last = start;
        while (last < FETCH_SLOTS - 1 && classify(exp.insts[last]) == QD_NORMAL) begin
            last++;
        end
        exp.avail = '0;
        for (int i = start; i <= last; i++) begin
            exp.avail[i] = 1'b1;
        end
        slot_pc = exp.base_pc + pc_t'(4 * last);
        seq_npc = slot_pc + pc_t'(4);
        case (classify(exp.insts[last]))
            QD_JAL: begin
                exp.pred_npc = slot_pc + jump_offset(exp.insts[last]);
            end
            QD_CALL: begin
                exp.pred_npc             = slot_pc + jump_offset(exp.insts[last]);
                model_ras[model_ras_ptr] = seq_npc;           // Oldest is overwritten.
                model_ras_ptr            = (model_ras_ptr + 1) % RAS_DEPTH;
                if (model_ras_cnt < RAS_DEPTH) begin
                    model_ras_cnt++;
                end
            end
            QD_RET: begin
                if (model_ras_cnt == 0) begin
                    exp.pred_npc = seq_npc;
                end else begin
                    model_ras_ptr = (model_ras_ptr + RAS_DEPTH - 1) % RAS_DEPTH;
                    exp.pred_npc  = model_ras[model_ras_ptr];
                    model_ras_cnt--;
                end
            end
            default: begin
                exp.pred_npc = seq_npc;                       // Branches not taken.
            end
        endcase
        model_pc = exp.pred_npc;
    endtask

    // --------------------------------------
    // Compare tasks
    // --------------------------------------
    task automatic check_pc(input string name, input pc_t exp, input pc_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_mask(input string name, input slot_mask_t exp, input slot_mask_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_inst(input string name, input inst_t exp, input inst_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic verify_group();
        fetch_grp_t exp;
        string      name;
        predict_group(exp);
        name = $sformatf("group %0d", groups);
        check_pc({name, " base_pc"}, exp.base_pc, grp_o.base_pc);
        check_mask({name, " avail"}, exp.avail, grp_o.avail);
        for (int i = 0; i < FETCH_SLOTS; i++) begin
            if (exp.avail[i]) begin
                check_inst($sformatf("%s slot %0d", name, i), exp.insts[i], grp_o.insts[i]);
            end
        end
        check_pc({name, " pred_npc"}, exp.pred_npc, grp_o.pred_npc);
        groups++;
    endtask

    task automatic drive_inputs();
        imem_ok_i = ({$random(seed)} % 4) != 0;          // About 75% success.
        for (int i = 0; i < FETCH_SLOTS; i++) begin
            imem_insts_i[i] = req_q ? mem_word(addr_q + pc_t'(4 * i)) : inst_t'($random(seed));
        end
        if (!redirect_i.en && ({$random(seed)} % 40) == 0) begin
            redirect_i.en = 1'b1;
            redirect_i.pc = pc_t'(({$random(seed)} % MEM_WORDS) * 4);
        end else begin
            redirect_i = '0;
        end
        fetch_en_i = ({$random(seed)} % 8) != 0;
        grp_rdy_i  = ({$random(seed)} % 2) != 0;
    endtask

    // --------------------------------------
    // Main sequence
    // --------------------------------------
    initial begin
        clk_i         = 1'b0;
        arst_n_i      = 1'b0;
        fetch_en_i    = 1'b0;
        redirect_i    = '0;
        imem_ok_i     = 1'b0;
        imem_insts_i  = '0;
        grp_rdy_i     = 1'b0;
        seed          = 32'h6e79;
        errors        = 0;
        groups        = 0;
        req_q         = 1'b0;
        addr_q        = '0;
        redirect_prev = 1'b0;
        fill_program();
        restart_model(BOOT_PC);
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        while (groups < MAX_GROUPS) begin
            @(negedge clk_i);
            drive_inputs();
            #1;
            req_q  = imem_req_o;
            addr_q = imem_addr_o;
            if (redirect_prev && grp_vld_o) begin
                errors++;
                $display("Group valid was high in the cycle after a redirect");
            end
            if (grp_vld_o && grp_rdy_i) begin
                verify_group();
            end
            // A transfer in the redirect cycle still belongs to the old stream.
            if (redirect_i.en) begin
                restart_model(redirect_i.pc);
            end
            redirect_prev = redirect_i.en;
        end
        $display("Checked %0d groups, %0d errors", groups, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(MAX_GROUPS * CYCLES_PER_GROUP * CLK_PERIOD);
        $display("Timeout, the group stream stalled after %0d groups", groups);
        $display("Checked %0d groups, %0d errors", groups, errors);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== sim.f ====
fetch_pkg.sv
fetch_pc_gen.sv
predecode.sv
group_select.sv
ras.sv
fetch_ibuf.sv
fetch_top.sv
tb_fetch_top.sv

// ==== Bender.yml ====
package:
  name: fetch_front

sources:
  - files:
      - fetch_pkg.sv
      - fetch_pc_gen.sv
      - predecode.sv
      - group_select.sv
      - ras.sv
      - fetch_ibuf.sv
      - fetch_top.sv
  - target: simulation
    files:
      - tb_fetch_top.sv
